//--- verilog/board_defs.svh
// register map, FIFO depth, debounce and ID constants; include wherever they are needed
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// event buffer
`define BOARD_FIFO_DEPTH 8

// debounce sample period in clock cycles and samples that must agree
`define BOARD_DEBOUNCE_RATE 156000
`define BOARD_DEBOUNCE_N 4

// value returned by the ID register
`define BOARD_ID 32'hB0A5_0001

// wishbone word addresses
`define REG_ID       3'd0
`define REG_STATUS   3'd1
`define REG_EVT_TS   3'd2
`define REG_EVT_DATA 3'd3
`define REG_GPIO     3'd4
`define REG_LED      3'd5

`endif

//--- verilog/board_pkg.sv
// shared types for the board-status block; referenced by scoped name from each module
package board_pkg;

    // SGMII PCS/PMA status vector, bit 0 is link_status
    typedef struct packed {
        logic [1:0] pause;
        logic       remote_fault;
        logic       duplex;
        logic [1:0] speed;
        logic [1:0] remote_fault_encdg;
        logic       phy_link_status;
        logic       rxnotintable;
        logic       rxdisperr;
        logic       rudi_invalid;
        logic       rudi_i;
        logic       rudi_c;
        logic       link_sync;
        logic       link_status;
    } pcs_status_fields_t;

    // field view for decode, byte view for the LED debug display
    typedef union packed {
        pcs_status_fields_t  fields;
        logic [1:0][7:0]     bytes;
    } pcs_status_u;

    // one recorded status change
    typedef struct packed {
        logic [15:0] timestamp;
        pcs_status_u status;
    } event_t;

    // buttons and switches, same order as the board pins
    typedef struct packed {
        logic       btnu;
        logic       btnl;
        logic       btnd;
        logic       btnr;
        logic       btnc;
        logic [3:0] sw;
    } gpio_t;

    // wishbone classic master request
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // wishbone classic slave response
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- verilog/debounce_switch.sv
// synchronizes and debounces the push buttons and switches before the host sees them
`timescale 1ns/1ps
`include "board_defs.svh"

module debounce_switch #(
    parameter int WIDTH = $bits(board_pkg::gpio_t),
    parameter int N     = `BOARD_DEBOUNCE_N,
    parameter int RATE  = `BOARD_DEBOUNCE_RATE
) (
    input  logic              clk_125mhz_i,
    input  logic              arst_n_i,
    input  board_pkg::gpio_t  in_i,
    output board_pkg::gpio_t  out_o
);

    localparam int CNT_W = (RATE > 1) ? $clog2(RATE) : 1;

    logic [WIDTH-1:0] in_bits;
    logic [WIDTH-1:0] sync0_q;
    logic [WIDTH-1:0] sync1_q;
    logic [WIDTH-1:0] out_q;
    logic [CNT_W-1:0] cnt_q;
    logic             sample;
    logic [N-1:0]     hist_q [WIDTH];

    assign in_bits = in_i;

    // one sample strobe every RATE cycles
    assign sample = (cnt_q == CNT_W'(RATE - 1));

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync0_q <= '0;
            sync1_q <= '0;
            cnt_q   <= '0;
        end else begin
            // two-flop synchronizer on the raw pins
            sync0_q <= in_bits;
            sync1_q <= sync0_q;
            if (sample) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
            for (int i = 0; i < WIDTH; i++) begin
                hist_q[i] <= '0;
            end
        end else if (sample) begin
            for (int i = 0; i < WIDTH; i++) begin
                hist_q[i] <= {hist_q[i][N-2:0], sync1_q[i]};
                // only move once the whole history agrees
                if (&hist_q[i]) begin
                    out_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    out_q[i] <= 1'b0;
                end
            end
        end
    end

    assign out_o = out_q;

endmodule

//--- verilog/pcs_status_monitor.sv
// watches the PCS status vector and emits a time-stamped record for every change
`timescale 1ns/1ps

module pcs_status_monitor (
    input  logic                    clk_125mhz_i,
    input  logic                    arst_n_i,
    input  board_pkg::pcs_status_u  status_i,
    output board_pkg::event_t       evt_o,
    output logic                    evt_valid_o,
    input  logic                    evt_ready_i,
    output board_pkg::pcs_status_u  live_o,
    output logic [7:0]              drop_count_o
);

    logic [15:0]            ts_q;
    board_pkg::pcs_status_u status_q;
    board_pkg::pcs_status_u last_q;
    board_pkg::event_t      evt_q;
    logic                   evt_valid_q;
    logic [7:0]             drop_q;
    logic                   changed;

    // registered value differs from the one before it
    assign changed = (status_q != last_q);

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ts_q        <= '0;
            status_q    <= '0;
            last_q      <= '0;
            evt_valid_q <= 1'b0;
            drop_q      <= '0;
        end else begin
            // free-running cycle counter for timestamps
            ts_q     <= ts_q + 16'd1;
            status_q <= status_i;
            // previous value follows even when the event is lost
            last_q   <= status_q;

            // single item in flight, offered for exactly one cycle
            evt_valid_q <= changed;

            // buffer full at push time, count the loss
            if (evt_valid_q && !evt_ready_i && (drop_q != 8'hff)) begin
                drop_q <= drop_q + 8'd1;
            end
        end
    end

    // stamp with the cycle the change was first seen
    always_ff @(posedge clk_125mhz_i) begin
        if (changed) begin
            evt_q.timestamp <= ts_q;
            evt_q.status    <= status_q;
        end
    end

    assign evt_o        = evt_q;
    assign evt_valid_o  = evt_valid_q;
    assign live_o       = status_q;
    assign drop_count_o = drop_q;

endmodule

//--- verilog/event_fifo.sv
// first-word-fall-through queue holding status events until the host reads them
`timescale 1ns/1ps
`include "board_defs.svh"

module event_fifo #(
    parameter int DEPTH = `BOARD_FIFO_DEPTH
) (
    input  logic                       clk_125mhz_i,
    input  logic                       arst_n_i,
    input  logic                       push_i,
    input  board_pkg::event_t          push_data_i,
    output logic                       push_ready_o,
    input  logic                       pop_i,
    output board_pkg::event_t          head_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH):0]     count_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    board_pkg::event_t mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              full;
    logic              empty;
    logic              do_push;
    logic              do_pop;

    assign full    = (count_q == CNT_W'(DEPTH));
    assign empty   = (count_q == '0);
    assign do_push = push_i && !full;
    // pop on an empty queue does nothing
    assign do_pop  = pop_i && !empty;

    always_ff @(posedge clk_125mhz_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // head is read straight out of the array
    assign head_o       = mem[rd_ptr_q];
    assign empty_o      = empty;
    assign push_ready_o = !full;
    assign count_o      = count_q;

endmodule

//--- verilog/wb_status_regs.sv
// wishbone classic register block: live status, event readout, GPIO and LED control
`timescale 1ns/1ps
`include "board_defs.svh"

module wb_status_regs (
    input  logic                                clk_125mhz_i,
    input  logic                                arst_n_i,
    input  board_pkg::wb_req_t                  wb_i,
    output board_pkg::wb_rsp_t                  wb_o,
    input  board_pkg::event_t                   head_i,
    input  logic                                empty_i,
    input  logic [$clog2(`BOARD_FIFO_DEPTH):0]  count_i,
    input  board_pkg::pcs_status_u              live_i,
    input  logic [7:0]                          drop_count_i,
    input  board_pkg::gpio_t                    gpio_i,
    output logic                                pop_o,
    output logic [7:0]                          led_o
);

    logic        req;
    logic        ack_q;
    logic        pop_q;
    logic [31:0] dat_q;
    logic [31:0] rd_data;
    logic [7:0]  led_val_q;
    logic        debug_q;
    logic        byte_sel_q;

    // new request, not yet answered
    assign req = wb_i.cyc && wb_i.stb && !ack_q;

    always_comb begin
        rd_data = '0;
        case (wb_i.adr)
            `REG_ID: begin
                rd_data = `BOARD_ID;
            end
            `REG_STATUS: begin
                rd_data[0]     = live_i.fields.link_status;
                rd_data[1]     = live_i.fields.link_sync;
                rd_data[2]     = live_i.fields.duplex;
                rd_data[3]     = live_i.fields.remote_fault;
                rd_data[4]     = live_i.fields.phy_link_status;
                rd_data[6:5]   = live_i.fields.speed;
                rd_data[11:8]  = count_i;
                rd_data[23:16] = drop_count_i;
            end
            `REG_EVT_TS: begin
                rd_data[15:0] = empty_i ? 16'h0 : head_i.timestamp;
            end
            `REG_EVT_DATA: begin
                // valid flag plus status word, all zero when nothing queued
                rd_data[16]   = !empty_i;
                rd_data[15:0] = empty_i ? 16'h0 : head_i.status;
            end
            `REG_GPIO: begin
                rd_data[8:0] = gpio_i;
            end
            `REG_LED: begin
                rd_data[9:0] = {byte_sel_q, debug_q, led_val_q};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q      <= 1'b0;
            pop_q      <= 1'b0;
            led_val_q  <= '0;
            debug_q    <= 1'b0;
            byte_sel_q <= 1'b0;
        end else begin
            // single-cycle ack, no wait states
            ack_q <= req;
            // pop lines up with the ack of an event read
            pop_q <= req && !wb_i.we && (wb_i.adr == `REG_EVT_DATA) && !empty_i;
            if (req && wb_i.we && (wb_i.adr == `REG_LED)) begin
                led_val_q  <= wb_i.dat[7:0];
                debug_q    <= wb_i.dat[8];
                byte_sel_q <= wb_i.dat[9];
            end
        end
    end

    // read data captured with the request
    always_ff @(posedge clk_125mhz_i) begin
        if (req) begin
            dat_q <= wb_i.we ? 32'h0 : rd_data;
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = dat_q;
    assign pop_o    = pop_q;

    // debug mode mirrors one byte of the live status vector
    assign led_o = debug_q ? live_i.bytes[byte_sel_q] : led_val_q;

endmodule

//--- verilog/board_status_top.sv
// board-status top level: status monitor, event buffer, debouncer and host registers
`timescale 1ns/1ps
`include "board_defs.svh"

module board_status_top #(
    parameter int DEBOUNCE_RATE = `BOARD_DEBOUNCE_RATE
) (
    input  logic                    clk_125mhz_i,
    input  logic                    arst_n_i,
    input  board_pkg::pcs_status_u  status_i,
    input  board_pkg::gpio_t        gpio_i,
    input  board_pkg::wb_req_t      wb_i,
    output board_pkg::wb_rsp_t      wb_o,
    output logic [7:0]              led_o
);

    board_pkg::event_t                   evt;
    logic                                evt_valid;
    logic                                evt_ready;
    board_pkg::event_t                   head;
    logic                                empty;
    logic [$clog2(`BOARD_FIFO_DEPTH):0]  count;
    logic                                pop;
    board_pkg::pcs_status_u              live;
    logic [7:0]                          drop_count;
    board_pkg::gpio_t                    gpio_stable;

    debounce_switch #(
        .WIDTH ($bits(board_pkg::gpio_t)),
        .N     (`BOARD_DEBOUNCE_N),
        .RATE  (DEBOUNCE_RATE)
    ) debounce_switch_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .in_i         (gpio_i),
        .out_o        (gpio_stable)
    );

    pcs_status_monitor status_monitor_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .status_i     (status_i),
        .evt_o        (evt),
        .evt_valid_o  (evt_valid),
        .evt_ready_i  (evt_ready),
        .live_o       (live),
        .drop_count_o (drop_count)
    );

    // push is valid and ready in the same cycle, gated inside the FIFO
    event_fifo #(
        .DEPTH (`BOARD_FIFO_DEPTH)
    ) event_fifo_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .push_i       (evt_valid),
        .push_data_i  (evt),
        .push_ready_o (evt_ready),
        .pop_i        (pop),
        .head_o       (head),
        .empty_o      (empty),
        .count_o      (count)
    );

    wb_status_regs status_regs_inst (
        .clk_125mhz_i (clk_125mhz_i),
        .arst_n_i     (arst_n_i),
        .wb_i         (wb_i),
        .wb_o         (wb_o),
        .head_i       (head),
        .empty_i      (empty),
        .count_i      (count),
        .live_i       (live),
        .drop_count_i (drop_count),
        .gpio_i       (gpio_stable),
        .pop_o        (pop),
        .led_o        (led_o)
    );

endmodule

//--- dv/tb_clkgen.sv
// free-running testbench clock source; instantiate once and feed clk_o to the DUT
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    // starts low, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

//--- dv/board_status_tb.sv
// pattern-driven testbench for board_status_top; run from the project root with verilog.f
`timescale 1ns/1ps
`include "board_defs.svh"

module board_status_tb;

    localparam int RESET_CYCLES = 10;
    localparam int ACK_WAIT     = 4;

    logic                   clk_125mhz;
    logic                   arst_n;
    board_pkg::pcs_status_u status;
    board_pkg::gpio_t       gpio;
    board_pkg::wb_req_t     wb_req;
    board_pkg::wb_rsp_t     wb_rsp;
    logic [7:0]             led;

    string       lines[$];
    string       test_name = "";
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int          checks = 0;
    int          total_checks = 0;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [15:0] last_ts;

    tb_clkgen #(.PERIOD_NS(8.0)) clkgen0 (.clk_o(clk_125mhz));

    board_status_top #(
        .DEBOUNCE_RATE (4)
    ) dut0 (
        .clk_125mhz_i (clk_125mhz),
        .arst_n_i     (arst_n),
        .status_i     (status),
        .gpio_i       (gpio),
        .wb_i         (wb_req),
        .wb_o         (wb_rsp),
        .led_o        (led)
    );

    // abort once the run outgrows its pattern budget
    always @(posedge clk_125mhz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("run stopped: cycle limit of %0d reached in test %s", cycle_limit, test_name);
            $display("Test failures found");
            $finish;
        end
    end

    // one classic transfer held until the edge after ack and followed by a random idle gap
    task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output bit got_ack);
        int waited;
        waited     = 0;
        got_ack    = 1'b0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk_125mhz);
        while (!wb_rsp.ack && waited < ACK_WAIT) begin
            waited++;
            @(negedge clk_125mhz);
        end
        if (!wb_rsp.ack) begin
            $display("no ack within %0d cycles for address %0d", ACK_WAIT + 1, adr);
            test_errors++;
        end else begin
            got_ack = 1'b1;
            rdat    = wb_rsp.dat;
            if (waited != 0) begin
                $display("ack arrived %0d cycles late at address %0d", waited, adr);
                test_errors++;
            end
        end
        @(negedge clk_125mhz);
        if (got_ack && wb_rsp.ack) begin
            $display("ack held longer than one cycle at address %0d", adr);
            test_errors++;
        end
        wb_req = '0;
        repeat ($urandom_range(4, 1)) @(negedge clk_125mhz);
    endtask

    task automatic close_test();
        if (test_name != "") begin
            $display("test %s done: %0d checks, %0d errors", test_name, checks, test_errors);
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
            end
        end
        total_checks += checks;
        total_errors += test_errors;
        checks       = 0;
        test_errors  = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          d_sum;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] arg0;
        logic [31:0] arg1;
        logic [31:0] rdat;
        bit          got_ack;
        bit          have_ts;

        status  = '0;
        gpio    = '0;
        wb_req  = '0;
        arst_n  = 1'b0;
        last_ts = '0;
        have_ts = 1'b0;
        d_sum   = 0;
        void'($urandom(10));

        fd = $fopen("dv/board_status_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/board_status_patterns.txt");
            total_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end

        // 64 cycles per command plus every idle wait and the reset
        foreach (lines[i]) begin
            n = $sscanf(lines[i], "%s %d", cmd, arg0);
            if (n == 2 && cmd == "D") begin
                d_sum += arg0;
            end
        end
        cycle_limit = lines.size() * 64 + d_sum + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk_125mhz);
        arst_n = 1'b1;
        @(negedge clk_125mhz);

        foreach (lines[i]) begin
            line = lines[i];
            n    = $sscanf(line, "%s", cmd);
            if (cmd == "T") begin
                close_test();
                n         = $sscanf(line, "%s %s", cmd, name);
                test_name = name;
                last_ts   = '0;
                have_ts   = 1'b0;
            end else if (cmd == "S") begin
                n      = $sscanf(line, "%s %h", cmd, arg0);
                status = arg0[15:0];
                @(negedge clk_125mhz);
            end else if (cmd == "G") begin
                n    = $sscanf(line, "%s %h", cmd, arg0);
                gpio = arg0[8:0];
                @(negedge clk_125mhz);
            end else if (cmd == "D") begin
                n = $sscanf(line, "%s %d", cmd, arg0);
                repeat (arg0) @(negedge clk_125mhz);
            end else if (cmd == "W") begin
                n = $sscanf(line, "%s %h %h", cmd, arg0, arg1);
                bus_cycle(1'b1, arg0[2:0], arg1, rdat, got_ack);
            end else if (cmd == "R") begin
                n = $sscanf(line, "%s %h %h", cmd, arg0, arg1);
                bus_cycle(1'b0, arg0[2:0], '0, rdat, got_ack);
                checks++;
                if (got_ack && rdat !== arg1) begin
                    $display("[FAIL] t=%0t wb_o.dat at address %0d: expected %h, actual %h",
                             $time, arg0[2:0], arg1, rdat);
                    test_errors++;
                end
            end else if (cmd == "L") begin
                n = $sscanf(line, "%s %h", cmd, arg0);
                checks++;
                if (led !== arg0[7:0]) begin
                    $display("[FAIL] t=%0t led_o: expected %h, actual %h", $time, arg0[7:0], led);
                    test_errors++;
                end
            end else if (cmd == "M") begin
                bus_cycle(1'b0, `REG_EVT_TS, '0, rdat, got_ack);
                // first timestamp of a test only sets the reference
                if (got_ack && have_ts) begin
                    checks++;
                    if (rdat[15:0] < last_ts) begin
                        $display({"[FAIL] t=%0t wb_o.dat event timestamp: ",
                                  "expected at least %h, actual %h"},
                                 $time, last_ts, rdat[15:0]);
                        test_errors++;
                    end
                end
                if (got_ack) begin
                    last_ts = rdat[15:0];
                    have_ts = 1'b1;
                end
            end else begin
                $display("unknown command in pattern line: %s", line);
                test_errors++;
            end
        end
        close_test();

        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && tests_run > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dv/board_status_patterns.txt
# columns: command then hex operands; T name, S status, G gpio, W addr data, R addr expected
# D cycles (decimal) idles, L expects led_o, M reads the head timestamp and expects no decrease
T reset_and_id
L 00
R 0 b0a50001
W 0 12345678
R 0 b0a50001
R 4 00000000
R 6 00000000
T led_write
W 5 0000005a
L 5a
R 5 0000005a
T status_debug_led
S 3a87
D 6
W 5 00000100
L 87
W 5 00000300
L 3a
R 5 00000300
R 1 0000015f
R 3 00013a87
R 1 0000005f
T event_order
S 0001
D 4
S 0003
D 4
S 0103
D 6
R 1 00000303
M
R 3 00010001
M
R 3 00010003
M
R 3 00010103
R 3 00000000
T overflow
S 0010
S 0020
S 0030
S 0040
S 0050
S 0060
S 0070
S 0080
S 0090
S 00a0
D 6
R 1 00020810
R 3 00010010
R 3 00010020
R 3 00010030
R 3 00010040
R 3 00010050
R 3 00010060
R 3 00010070
R 3 00010080
R 3 00000000
R 1 00020010
T gpio_debounce
G 1a5
D 30
R 4 000001a5
G 1e5
G 1a5
D 30
R 4 000001a5

//--- verilog.f
+incdir+verilog
verilog/board_pkg.sv
verilog/debounce_switch.sv
verilog/pcs_status_monitor.sv
verilog/event_fifo.sv
verilog/wb_status_regs.sv
verilog/board_status_top.sv
dv/tb_clkgen.sv
dv/board_status_tb.sv

//--- Bender.yml
package:
  name: board_status

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/board_pkg.sv
      - verilog/debounce_switch.sv
      - verilog/pcs_status_monitor.sv
      - verilog/event_fifo.sv
      - verilog/wb_status_regs.sv
      - verilog/board_status_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_clkgen.sv
      - dv/board_status_tb.sv
